// File: src/line_bus_pkg.sv
/* Line bus shared definitions */

`default_nettype none

package line_bus_pkg;

   // Bus and line geometry
   localparam int WORD_W     = 32;
   localparam int ADDR_W     = 16;
   localparam int LINE_W     = 128;
   localparam int SIZE_W     = 12;

   // Size counter start value and step, in bytes
   localparam logic [SIZE_W-1:0] LINE_BYTES = 12'd16;
   localparam logic [SIZE_W-1:0] BEAT_BYTES = 12'd4;

   // Memory slave depth, 1 KiB of words
   localparam int MEM_WORDS  = 256;
   localparam int MEM_IDX_W  = $clog2(MEM_WORDS);

   // Beats per line and the width of the beat counter
   localparam int BEAT_CNT_W = 3;
   localparam logic [BEAT_CNT_W-1:0] LINE_WORDS = 3'd4;

   // Two masters share the bus
   localparam int N_PORTS    = 2;

   // Controller one-hot state bit positions
   localparam int N_STATES   = 5;
   localparam int S_IDLE     = 0;
   localparam int S_REQ      = 1;
   localparam int S_MSTR     = 2;
   localparam int S_XFER     = 3;
   localparam int S_DONE     = 4;

   // Work unit to controller
   typedef struct packed {
      logic              en;
      logic              wr;
      logic [ADDR_W-1:0] addr;
      logic [LINE_W-1:0] wdata;
   } line_req_t;

   // Controller back to work unit
   typedef struct packed {
      logic [LINE_W-1:0] rdata;
      logic              ready;
   } line_rsp_t;

   // Owning master onto the bus
   typedef struct packed {
      logic              cmd;
      logic              rw;
      logic [ADDR_W-1:0] addr;
      logic [SIZE_W-1:0] size;
      logic [WORD_W-1:0] wdata;
   } bus_req_t;

   // Memory slave back to the masters
   typedef struct packed {
      logic              ack;
      logic [WORD_W-1:0] rdata;
   } bus_rsp_t;

endpackage

`default_nettype wire

// File: src/cache_bus_controller.sv
/* Cache bus controller */

`default_nettype none

module cache_bus_controller (
   input  wire                           bus_clk,
   input  wire                           rst,
   // Work unit side
   input  wire line_bus_pkg::line_req_t  unit_req,
   output line_bus_pkg::line_rsp_t       unit_rsp,
   // Arbiter side
   output logic                          br,
   input  wire                           bg,
   // Shared bus side
   output line_bus_pkg::bus_req_t        bus_req,
   input  wire line_bus_pkg::bus_rsp_t   bus_rsp
);

   // One-hot state
   logic [line_bus_pkg::N_STATES-1:0] state;
   logic [line_bus_pkg::N_STATES-1:0] state_nxt;

   // Beat size counter, 16 down to 0 in steps of 4
   logic [line_bus_pkg::SIZE_W-1:0]   size;
   logic [line_bus_pkg::SIZE_W-1:0]   size_dec;
   logic [1:0]                        slot;

   // Captured request and line buffer
   line_bus_pkg::line_req_t           req_q;
   logic [line_bus_pkg::LINE_W-1:0]   line_buf;

   logic                              accept;
   logic                              beat;
   logic                              last_beat;

   assign accept    = state[line_bus_pkg::S_IDLE] & unit_req.en;
   assign beat      = state[line_bus_pkg::S_XFER] & bus_rsp.ack;
   assign last_beat = beat & (size == line_bus_pkg::BEAT_BYTES);

   // Buffer slot rises as the size falls
   assign size_dec = size - line_bus_pkg::BEAT_BYTES;
   assign slot     = ~size_dec[3:2];

   // Next state
   always_comb begin
      state_nxt = '0;
      case (1'b1)
         state[line_bus_pkg::S_IDLE]: begin
            state_nxt[unit_req.en ? line_bus_pkg::S_REQ : line_bus_pkg::S_IDLE] = 1'b1;
         end
         state[line_bus_pkg::S_REQ]: begin
            // Wait here for as long as the grant takes
            state_nxt[(bg && br) ? line_bus_pkg::S_MSTR : line_bus_pkg::S_REQ] = 1'b1;
         end
         state[line_bus_pkg::S_MSTR]: begin
            state_nxt[line_bus_pkg::S_XFER] = 1'b1;
         end
         state[line_bus_pkg::S_XFER]: begin
            state_nxt[last_beat ? line_bus_pkg::S_DONE : line_bus_pkg::S_XFER] = 1'b1;
         end
         state[line_bus_pkg::S_DONE]: begin
            state_nxt[line_bus_pkg::S_IDLE] = 1'b1;
         end
         default: begin
            state_nxt[line_bus_pkg::S_IDLE] = 1'b1;
         end
      endcase
   end

   // Control registers
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state                       <= '0;
         state[line_bus_pkg::S_IDLE] <= 1'b1;
         br                          <= 1'b0;
         size                        <= '0;
      end else begin
         state <= state_nxt;
         // Bus request goes up one cycle after accept
         if (state[line_bus_pkg::S_REQ]) begin
            br <= 1'b1;
         end else if (last_beat) begin
            br <= 1'b0;
         end
         if (accept) begin
            size <= line_bus_pkg::LINE_BYTES;
         end else if (beat) begin
            size <= size_dec;
         end
      end
   end

   // Payload registers
   always_ff @(posedge bus_clk) begin
      if (accept) begin
         req_q <= unit_req;
      end
      // Read data lands in the slot picked by the size
      if (beat && !req_q.wr) begin
         line_buf[slot*line_bus_pkg::WORD_W +: line_bus_pkg::WORD_W] <= bus_rsp.rdata;
      end
   end

   // Address phase for one cycle, then one word per ack
   assign bus_req.cmd   = state[line_bus_pkg::S_MSTR];
   assign bus_req.rw    = req_q.wr;
   assign bus_req.addr  = req_q.addr;
   assign bus_req.size  = line_bus_pkg::LINE_BYTES;   // always a full line
   assign bus_req.wdata = state[line_bus_pkg::S_XFER] ?
                          req_q.wdata[slot*line_bus_pkg::WORD_W +: line_bus_pkg::WORD_W] : '0;

   // Done state is the one-cycle ready pulse
   assign unit_rsp.rdata = line_buf;
   assign unit_rsp.ready = state[line_bus_pkg::S_DONE];

endmodule

`default_nettype wire

// File: src/bus_arbiter.sv
/* Fixed-priority bus arbiter */

`default_nettype none

module bus_arbiter (
   input  wire                              bus_clk,
   input  wire                              rst,
   input  wire [line_bus_pkg::N_PORTS-1:0]  br,
   output logic [line_bus_pkg::N_PORTS-1:0] bg
);

   logic [line_bus_pkg::N_PORTS-1:0] pick;
   logic                             held;

   // Current owner still wants the bus
   assign held = |(bg & br);

   // Lowest requesting port wins
   always_comb begin
      pick = '0;
      for (int p = line_bus_pkg::N_PORTS - 1; p >= 0; p--) begin
         if (br[p]) begin
            pick    = '0;
            pick[p] = 1'b1;
         end
      end
   end

   // Grant register with hold
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         bg <= '0;
      end else if (!held) begin
         // Release and regrant happen on the same edge
         bg <= pick;
      end
   end

endmodule

`default_nettype wire

// File: src/line_memory.sv
/* Line memory slave */

`default_nettype none

module line_memory (
   input  wire                          bus_clk,
   input  wire                          rst,
   input  wire line_bus_pkg::bus_req_t  bus_req,
   output line_bus_pkg::bus_rsp_t       bus_rsp
);

   // Word storage
   logic [line_bus_pkg::WORD_W-1:0]     mem [line_bus_pkg::MEM_WORDS];

   // Beats left in the current burst
   logic [line_bus_pkg::BEAT_CNT_W-1:0] beats;

   // Word index of the beat being acknowledged
   logic [line_bus_pkg::MEM_IDX_W-1:0]  idx;
   logic [line_bus_pkg::MEM_IDX_W-1:0]  idx_nxt;
   logic [line_bus_pkg::MEM_IDX_W-1:0]  cmd_idx;

   logic                                rw_q;
   logic [line_bus_pkg::WORD_W-1:0]     rdata_q;
   logic                                beat;

   // Byte address to word index, bits 9 to 2
   assign cmd_idx = bus_req.addr[line_bus_pkg::MEM_IDX_W+1:2];
   assign idx_nxt = idx + 1'b1;
   assign beat    = (beats != '0);

   // Beat counter
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         beats <= '0;
      end else if (bus_req.cmd) begin
         beats <= line_bus_pkg::LINE_WORDS;
      end else if (beat) begin
         beats <= beats - 1'b1;
      end
   end

   // Command latch and data path
   always_ff @(posedge bus_clk) begin
      if (bus_req.cmd) begin
         idx     <= cmd_idx;
         rw_q    <= bus_req.rw;
         // First read word is ready with the first ack
         rdata_q <= mem[cmd_idx];
      end else if (beat) begin
         idx     <= idx_nxt;
         rdata_q <= mem[idx_nxt];
         // Master drives the matching word during each ack
         if (rw_q) begin
            mem[idx] <= bus_req.wdata;
         end
      end
   end

   // Ack high on every beat cycle
   assign bus_rsp.ack   = beat;
   assign bus_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// File: src/line_bus_top.sv
/* Line bus top level */

`default_nettype none

module line_bus_top (
   input  wire                           bus_clk,
   input  wire                           rst,
   input  wire line_bus_pkg::line_req_t  unit_req [line_bus_pkg::N_PORTS],
   output line_bus_pkg::line_rsp_t       unit_rsp [line_bus_pkg::N_PORTS]
);

   // Request and grant pairs
   logic [line_bus_pkg::N_PORTS-1:0] br;
   logic [line_bus_pkg::N_PORTS-1:0] bg;

   // Per-master bus drive and the shared bus
   line_bus_pkg::bus_req_t           ctrl_req [line_bus_pkg::N_PORTS];
   line_bus_pkg::bus_req_t           mem_req;
   line_bus_pkg::bus_rsp_t           mem_rsp;

   // Port 0 serves the data cache
   cache_bus_controller ctrl0 (
      .bus_clk  (bus_clk),
      .rst      (rst),
      .unit_req (unit_req[0]),
      .unit_rsp (unit_rsp[0]),
      .br       (br[0]),
      .bg       (bg[0]),
      .bus_req  (ctrl_req[0]),
      .bus_rsp  (mem_rsp)
   );

   // Port 1 serves the instruction cache
   cache_bus_controller ctrl1 (
      .bus_clk  (bus_clk),
      .rst      (rst),
      .unit_req (unit_req[1]),
      .unit_rsp (unit_rsp[1]),
      .br       (br[1]),
      .bg       (bg[1]),
      .bus_req  (ctrl_req[1]),
      .bus_rsp  (mem_rsp)
   );

   bus_arbiter arb0 (
      .bus_clk (bus_clk),
      .rst     (rst),
      .br      (br),
      .bg      (bg)
   );

   // Owner multiplexer, idle bus when nothing granted
   always_comb begin
      mem_req = '0;
      for (int p = 0; p < line_bus_pkg::N_PORTS; p++) begin
         if (bg[p]) begin
            mem_req = ctrl_req[p];
         end
      end
   end

   line_memory mem0 (
      .bus_clk (bus_clk),
      .rst     (rst),
      .bus_req (mem_req),
      .bus_rsp (mem_rsp)
   );

endmodule

`default_nettype wire

// File: dv/tb_line_bus.sv
/* Line bus testbench */

`default_nettype none

module tb_line_bus;

   logic                    bus_clk;
   logic                    rst;
   line_bus_pkg::line_req_t unit_req [line_bus_pkg::N_PORTS];
   line_bus_pkg::line_rsp_t unit_rsp [line_bus_pkg::N_PORTS];

   // Shadow memory, one entry per 16-byte line
   logic [line_bus_pkg::LINE_W-1:0] shadow [64];
   bit                              written [64];
   logic [5:0]                      written_q [$];

   // Expected read line and per-port bookkeeping
   logic [line_bus_pkg::LINE_W-1:0] exp_line [line_bus_pkg::N_PORTS];
   logic                            rd_pend [line_bus_pkg::N_PORTS];
   logic                            busy [line_bus_pkg::N_PORTS];
   int                              lat [line_bus_pkg::N_PORTS];
   logic                            lat_chk = 1'b1;
   logic                            dual = 1'b0;
   logic [31:0]                     lcg_state = 32'd57447;
   int                              cycles = 0;
   string                           test_name = "reset";

   line_bus_top dut0 (
      .bus_clk  (bus_clk),
      .rst      (rst),
      .unit_req (unit_req),
      .unit_rsp (unit_rsp)
   );

   initial begin
      bus_clk = 1'b0;
      forever #5 bus_clk = ~bus_clk;
   end

   function automatic logic [31:0] rand32();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [line_bus_pkg::LINE_W-1:0] rand_line();
      return {rand32(), rand32(), rand32(), rand32()};
   endfunction

   // Random line that holds no data yet
   function automatic logic [5:0] fresh_line();
      logic [31:0] r;
      do begin
         r = rand32();
      end while (written[r[21:16]]);
      return r[21:16];
   endfunction

   task automatic stop_on_error();
      $display("Test failed");
      $fatal(1, "stopping at the first error");
   endtask

   // One line through a port, returns on the edge that samples ready
   task automatic run_line(input int p, input logic wr, input logic [5:0] line,
                           input logic [line_bus_pkg::LINE_W-1:0] data);
      line_bus_pkg::line_req_t req;
      req.en    = 1'b1;
      req.wr    = wr;
      req.addr  = {6'd0, line, 4'd0};
      req.wdata = data;
      unit_req[p] <= req;
      rd_pend[p]  <= !wr;
      exp_line[p] <= shadow[line];
      do begin
         @(posedge bus_clk);
      end while (!unit_rsp[p].ready);
      // A following call on this edge overrides the drop
      unit_req[p].en <= 1'b0;
      if (wr) begin
         shadow[line] = data;
         if (!written[line]) begin
            written[line] = 1'b1;
            written_q.push_back(line);
         end
      end
   endtask

   // Accept happens on an edge where the port is idle and en is high
   always @(posedge bus_clk) begin
      for (int p = 0; p < line_bus_pkg::N_PORTS; p++) begin
         if (rst) begin
            busy[p] <= 1'b0;
            lat[p]  <= 0;
         end else if (!busy[p] && unit_req[p].en) begin
            busy[p] <= 1'b1;
            lat[p]  <= 0;
         end else if (busy[p] && unit_rsp[p].ready) begin
            busy[p] <= 1'b0;
         end else if (busy[p]) begin
            lat[p]  <= lat[p] + 1;
         end
      end
   end

   // About 40 lines of at most 20 cycles each, with margin
   always @(posedge bus_clk) begin
      cycles <= cycles + 1;
      if (cycles >= 2000) begin
         $display("timeout: transaction never completed");
         stop_on_error();
      end
   end

   assert property (@(posedge bus_clk)
      (rst || $past(rst)) |-> !(unit_rsp[0].ready || unit_rsp[1].ready))
   else begin
      $display("[FAIL] %s: expected ready 0, actual ready 1", test_name);
      stop_on_error();
   end

   // Port 1 may not finish before port 0 when both start together
   assert property (@(posedge bus_clk) disable iff (rst)
      (unit_rsp[1].ready && dual) |-> (unit_rsp[0].ready || !busy[0]))
   else begin
      $display("[FAIL] %s: expected port 0 done 1, actual 0", test_name);
      stop_on_error();
   end

   for (genvar p = 0; p < line_bus_pkg::N_PORTS; p++) begin : g_port_chk
      assert property (@(posedge bus_clk) disable iff (rst)
         (unit_rsp[p].ready && rd_pend[p]) |-> (unit_rsp[p].rdata == exp_line[p]))
      else begin
         $display("[FAIL] %s port %0d: expected %h, actual %h", test_name, p,
                  $sampled(exp_line[p]), $sampled(unit_rsp[p].rdata));
         stop_on_error();
      end

      assert property (@(posedge bus_clk) disable iff (rst)
         (unit_rsp[p].ready && lat_chk) |-> (lat[p] == 8))
      else begin
         $display("[FAIL] %s port %0d: expected latency 8, actual %0d", test_name, p,
                  $sampled(lat[p]));
         stop_on_error();
      end

      assert property (@(posedge bus_clk) disable iff (rst)
         $past(unit_rsp[p].ready) |-> !unit_rsp[p].ready)
      else begin
         $display("[FAIL] %s port %0d: expected ready 0, actual 1", test_name, p);
         stop_on_error();
      end
   end

   initial begin
      int          i;
      int          k;
      logic [31:0] r;
      logic [5:0]  a;
      rst = 1'b1;
      for (int p = 0; p < line_bus_pkg::N_PORTS; p++) begin
         unit_req[p] = '0;
      end
      repeat (5) @(posedge bus_clk);
      rst <= 1'b0;
      repeat (3) @(posedge bus_clk);

      // Port 0 fills four lines, both ports read them back
      test_name = "write_read";
      for (i = 0; i < 4; i++) begin
         run_line(0, 1'b1, fresh_line(), rand_line());
         repeat (2) @(posedge bus_clk);
      end
      for (i = 0; i < 4; i++) begin
         run_line(i % 2, 1'b0, written_q[i], '0);
         repeat (2) @(posedge bus_clk);
      end

      test_name = "uncontended_latency";
      a = fresh_line();
      run_line(1, 1'b1, a, rand_line());
      repeat (2) @(posedge bus_clk);
      run_line(0, 1'b0, a, '0);
      repeat (2) @(posedge bus_clk);

      // Both ports start reads of different lines on one edge
      test_name = "side_by_side";
      lat_chk <= 1'b0;
      dual    <= 1'b1;
      for (i = 0; i < 3; i++) begin
         r = rand32();
         k = (r >> 16) % written_q.size();
         fork
            run_line(0, 1'b0, written_q[k], '0);
            run_line(1, 1'b0, written_q[(k + 1) % written_q.size()], '0);
         join
         repeat (2) @(posedge bus_clk);
      end
      lat_chk <= 1'b1;
      dual    <= 1'b0;
      @(posedge bus_clk);

      // Port 0 keeps en high across random reads and writes
      test_name = "back_to_back";
      for (i = 0; i < 24; i++) begin
         r = rand32();
         if (r[8]) begin
            run_line(0, 1'b1, r[21:16], rand_line());
         end else begin
            k = (r >> 16) % written_q.size();
            run_line(0, 1'b0, written_q[k], '0);
         end
      end
      repeat (4) @(posedge bus_clk);

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
src/line_bus_pkg.sv
src/cache_bus_controller.sv
src/bus_arbiter.sv
src/line_memory.sv
src/line_bus_top.sv
dv/tb_line_bus.sv

// File: build.sh
#!/usr/bin/env bash
# Compile and run the line bus testbench, exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_line_bus -f project.f -o tb_line_bus \
   && ./obj_dir/tb_line_bus \
   || exit 1
